/* all.f */
common/board_pkg.sv
common/sys_pkg.sv
logic/reset_sync.sv
logic/heartbeat_counter.sv
boot/boot_fsm.sv
boot/flash_reader.sv
logic/image_checksum.sv
logic/board_top.sv
verif/spi_flash_model.sv
verif/tb_board_top.sv

/* verif/tb_board_top.sv */
// board_top testbench covering flash boot, host boot, heartbeat and a reset mid flash load
// flash and host words are random from a fixed seed
`timescale 1ns/1ps
`default_nettype none

module tb_board_top;

  localparam int unsigned            WORDS          = 4;
  localparam int                     HEARTBEAT_BITS = 6;
  localparam board_pkg::flash_addr_t FLASH_BASE     = 24'h000100;
  localparam int                     IMAGE_WORDS    = 16;
  localparam int                     HALF_BLINK     = 2 ** (HEARTBEAT_BITS - 1);
  localparam int TIMEOUT_CYCLES = 2 * (32 + 32 * WORDS) * 2 + (2 ** HEARTBEAT_BITS) * 2 + 200;

  logic                   clk_gen = 1'b0;
  logic                   rst_i;
  logic                   boot_select_i;
  sys_pkg::beat_t         host_beat;
  board_pkg::spi_pins_t   spi;
  logic                   miso;
  logic                   rst_led;
  logic                   clk_led;
  logic                   clk_out;
  logic                   exit_valid;
  logic                   exit_led;
  sys_pkg::word_t         exit_value;
  board_pkg::flash_cmd_t  flash_cmd;
  board_pkg::flash_addr_t flash_addr;
  sys_pkg::word_t         flash_image [IMAGE_WORDS];
  int unsigned            cycle_count = 0;
  logic                   watch_csb = 1'b0;

  board_top #(
    .WORDS          (WORDS),
    .HEARTBEAT_BITS (HEARTBEAT_BITS),
    .FLASH_BASE     (FLASH_BASE)
  ) dut (
    .clk_gen       (clk_gen),
    .rst_i         (rst_i),
    .boot_select_i (boot_select_i),
    .host_beat_i   (host_beat),
    .spi_miso_i    (miso),
    .spi_o         (spi),
    .rst_led_o     (rst_led),
    .clk_led_o     (clk_led),
    .clk_out_o     (clk_out),
    .exit_valid_o  (exit_valid),
    .exit_value_o  (exit_value),
    .exit_led_o    (exit_led)
  );

  spi_flash_model #(
    .MEM_WORDS (IMAGE_WORDS)
  ) flash (
    .spi_i  (spi),
    .miso_o (miso),
    .cmd_o  (flash_cmd),
    .addr_o (flash_addr)
  );

  always #2 clk_gen = ~clk_gen;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic compare_word(input sys_pkg::word_t got, input sys_pkg::word_t exp,
                              input string what);
    assert (got === exp) else begin
      abort_run($sformatf("ERR t=%0t %s: got %h, expected %h", $time, what, got, exp));
    end
  endtask

  always @(posedge clk_gen) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      abort_run($sformatf("run timed out after %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // the flash must stay deselected through a host boot
  always @(negedge clk_gen) begin
    if (watch_csb) begin
      compare_word(spi.csb, 1'b1, "csb during host boot");
    end
  end

  // clk_out sampled in the middle of each clk_gen phase
  always @(posedge clk_gen) begin
    #1;
    compare_word(clk_out, 1'b1, "clock out high phase");
  end

  always @(negedge clk_gen) begin
    #1;
    compare_word(clk_out, 1'b0, "clock out low phase");
  end

  task automatic check_idle(input string phase);
    compare_word(spi.csb, 1'b1, {"csb ", phase});
    compare_word(spi.sck, 1'b0, {"sck ", phase});
    compare_word(spi.mosi, 1'b0, {"mosi ", phase});
    compare_word(exit_valid, 1'b0, {"exit valid ", phase});
    compare_word(exit_value, '0, {"exit value ", phase});
    compare_word(clk_led, 1'b0, {"heartbeat led ", phase});
  endtask

  // returns on the first falling edge that sees rst_n released
  task automatic apply_reset(input logic select);
    @(negedge clk_gen);
    rst_i = 1'b1;
    repeat (3) @(negedge clk_gen);
    check_idle("in reset");
    compare_word(rst_led, 1'b0, "reset led in reset");
    boot_select_i = select;
    rst_i = 1'b0;
    @(negedge clk_gen);
    while (!rst_led) begin
      @(negedge clk_gen);
    end
    check_idle("after reset");
  endtask

  task automatic fill_flash;
    for (int i = 0; i < IMAGE_WORDS; i++) begin
      flash_image[i] = $urandom();
      flash.mem[i] = flash_image[i];
    end
  endtask

  task automatic wait_exit;
    while (!exit_valid) begin
      @(negedge clk_gen);
    end
  endtask

  task automatic check_flash_boot;
    sys_pkg::word_t sum;
    sum = '0;
    for (int i = 0; i < WORDS; i++) begin
      sum += flash_image[i];
    end
    wait_exit();
    compare_word(exit_value, sum, "flash checksum");
    compare_word(exit_led, sum[0], "exit led");
    compare_word(flash_cmd, board_pkg::FLASH_READ_CMD, "flash read command");
    compare_word(flash_addr, FLASH_BASE, "flash read address");
  endtask

  task automatic measure_heartbeat;
    int unsigned cycles;
    logic        level;
    cycles = 0;
    while (!clk_led) begin
      @(negedge clk_gen);
      cycles++;
    end
    compare_word(cycles, HALF_BLINK, "first heartbeat rise");
    for (int t = 0; t < 3; t++) begin
      level = clk_led;
      cycles = 0;
      while (clk_led == level) begin
        @(negedge clk_gen);
        cycles++;
      end
      compare_word(cycles, HALF_BLINK, "heartbeat toggle interval");
    end
  endtask

  task automatic send_host_word(input sys_pkg::word_t w);
    repeat (1 + $urandom() % 4) @(negedge clk_gen);
    host_beat.valid = 1'b1;
    host_beat.word = w;
    @(negedge clk_gen);
    host_beat.valid = 1'b0;
  endtask

  initial begin
    sys_pkg::word_t host_sum;
    sys_pkg::word_t w;
    int unsigned    seed_ret;
    rst_i = 1'b1;
    boot_select_i = 1'b0;
    host_beat = '0;
    host_sum = '0;
    seed_ret = $urandom(50475);
    fill_flash();

    // heartbeat timed from the same release as the flash boot
    apply_reset(1'b1);
    fork
      measure_heartbeat();
      check_flash_boot();
    join

    apply_reset(1'b0);
    watch_csb = 1'b1;
    for (int i = 0; i < WORDS; i++) begin
      w = $urandom();
      host_sum += w;
      send_host_word(w);
    end
    wait_exit();
    compare_word(exit_value, host_sum, "host checksum");
    // late beats are dropped
    send_host_word($urandom());
    send_host_word($urandom());
    repeat (4) @(negedge clk_gen);
    compare_word(exit_value, host_sum, "exit value after late host beats");
    compare_word(exit_valid, 1'b1, "exit valid after late host beats");
    watch_csb = 1'b0;

    // reset lands in the middle of a flash load
    apply_reset(1'b1);
    repeat (40) @(negedge clk_gen);
    compare_word(spi.csb, 1'b0, "csb during flash load");
    fill_flash();
    apply_reset(1'b1);
    check_flash_boot();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/spi_flash_model.sv */
// behavioral single-lane SPI flash, streams mem from word 0 on every read
// mem is loaded by the testbench; the last header seen stays on cmd_o and addr_o
`timescale 1ns/1ps
`default_nettype none

module spi_flash_model #(
  parameter int MEM_WORDS = 16
) (
  input  board_pkg::spi_pins_t   spi_i,
  output logic                   miso_o,
  output board_pkg::flash_cmd_t  cmd_o,
  output board_pkg::flash_addr_t addr_o
);

  sys_pkg::word_t mem [MEM_WORDS];
  logic           csb;
  logic           sck;
  logic [31:0]    hdr_q = '0;
  int unsigned    rise_cnt = 0;
  int unsigned    bit_cnt = 0;

  assign csb = spi_i.csb;
  assign sck = spi_i.sck;
  assign {cmd_o, addr_o} = hdr_q;

  // command and address sampled on rising sck
  always @(posedge sck or posedge csb) begin
    if (csb) begin
      rise_cnt <= 0;
    end else begin
      if (rise_cnt < 32) begin
        hdr_q <= {hdr_q[30:0], spi_i.mosi};
      end
      rise_cnt <= rise_cnt + 1;
    end
  end

  // data changes on falling sck, MSB first
  always @(negedge sck or posedge csb) begin
    if (csb) begin
      bit_cnt <= 0;
      miso_o  <= 1'b0;
    end else if (rise_cnt >= 32) begin
      miso_o  <= mem[(bit_cnt / 32) % MEM_WORDS][31 - (bit_cnt % 32)];
      bit_cnt <= bit_cnt + 1;
    end
  end

endmodule

`default_nettype wire

/* logic/board_top.sv */
// board wrapper: reset sync, blink led, flash or host boot, checksum exit
// clk_gen comes straight from the board, no clock wizard in front
`timescale 1ns/1ps
`default_nettype none

module board_top #(
  parameter int unsigned            WORDS          = 4,
  parameter int                     HEARTBEAT_BITS = 27,
  parameter board_pkg::flash_addr_t FLASH_BASE     = '0
) (
  input  logic                 clk_gen,
  input  logic                 rst_i,
  input  logic                 boot_select_i,
  input  sys_pkg::beat_t       host_beat_i,
  input  logic                 spi_miso_i,
  output board_pkg::spi_pins_t spi_o,
  output logic                 rst_led_o,
  output logic                 clk_led_o,
  output logic                 clk_out_o,
  output logic                 exit_valid_o,
  output sys_pkg::word_t       exit_value_o,
  output logic                 exit_led_o
);

  logic           rst_n;
  logic           flash_start;
  logic           boot_done;
  sys_pkg::beat_t flash_beat;
  sys_pkg::beat_t boot_beat;
  sys_pkg::exit_t sys_exit;

  reset_sync u_reset_sync (
    .clk_gen (clk_gen),
    .rst_i   (rst_i),
    .rst_n_o (rst_n)
  );

  heartbeat_counter #(
    .HEARTBEAT_BITS (HEARTBEAT_BITS)
  ) u_heartbeat (
    .clk_gen (clk_gen),
    .rst_n   (rst_n),
    .led_o   (clk_led_o)
  );

  boot_fsm #(
    .WORDS (WORDS)
  ) u_boot_fsm (
    .clk_gen       (clk_gen),
    .rst_n         (rst_n),
    .boot_select_i (boot_select_i),
    .host_beat_i   (host_beat_i),
    .flash_beat_i  (flash_beat),
    .flash_start_o (flash_start),
    .beat_o        (boot_beat),
    .done_o        (boot_done)
  );

  flash_reader #(
    .FLASH_BASE (FLASH_BASE)
  ) u_flash_reader (
    .clk_gen (clk_gen),
    .rst_n   (rst_n),
    .start_i (flash_start),
    .spi_o   (spi_o),
    .miso_i  (spi_miso_i),
    .beat_o  (flash_beat)
  );

  image_checksum u_checksum (
    .clk_gen (clk_gen),
    .rst_n   (rst_n),
    .beat_i  (boot_beat),
    .done_i  (boot_done),
    .exit_o  (sys_exit)
  );

  assign rst_led_o    = rst_n;
  assign clk_out_o    = clk_gen;
  assign exit_valid_o = sys_exit.valid;
  assign exit_value_o = sys_exit.value;
  // one bit of the result for the led
  assign exit_led_o   = sys_exit.value[0];

endmodule

`default_nettype wire

/* logic/image_checksum.sv */
// wrapping 32-bit sum of the boot image
// exit holds its value and valid level until the next reset
`timescale 1ns/1ps
`default_nettype none

module image_checksum (
  input  logic           clk_gen,
  input  logic           rst_n,
  input  sys_pkg::beat_t beat_i,
  input  logic           done_i,
  output sys_pkg::exit_t exit_o
);

  sys_pkg::word_t sum_q;
  logic           valid_q;

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      sum_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      // frozen once exit is valid
      if (beat_i.valid && !valid_q) begin
        sum_q <= sum_q + beat_i.word;
      end
      if (done_i) begin
        valid_q <= 1'b1;
      end
    end
  end

  assign exit_o.valid = valid_q;
  assign exit_o.value = sum_q;

endmodule

`default_nettype wire

/* boot/flash_reader.sv */
// single-lane SPI read: command, 24-bit address, then words until start drops
// sck runs at clk_gen/2 and rests low; miso sampled on rising sck, MSB first
`timescale 1ns/1ps
`default_nettype none

module flash_reader #(
  parameter board_pkg::flash_addr_t FLASH_BASE = '0
) (
  input  logic                 clk_gen,
  input  logic                 rst_n,
  input  logic                 start_i,
  output board_pkg::spi_pins_t spi_o,
  input  logic                 miso_i,
  output sys_pkg::beat_t       beat_o
);

  localparam int HDR_BITS = board_pkg::FLASH_CMD_BITS + board_pkg::FLASH_ADDR_BITS;
  localparam int HDR_CNT_BITS = $clog2(HDR_BITS + 1);
  localparam int DATA_CNT_BITS = $clog2(sys_pkg::WORD_BITS);

  logic                     csb_q;
  logic                     sck_q;
  logic                     active;
  logic                     sck_rise;
  logic                     sck_fall;
  logic                     hdr_done;
  logic [HDR_BITS-1:0]      hdr_q;
  logic [HDR_CNT_BITS-1:0]  hdr_cnt_q;
  logic [DATA_CNT_BITS-1:0] data_cnt_q;
  logic                     beat_valid_q;
  sys_pkg::word_t           data_q;

  assign active   = start_i && !csb_q;
  assign sck_rise = active && !sck_q;
  assign sck_fall = active && sck_q;
  assign hdr_done = (hdr_cnt_q == HDR_CNT_BITS'(HDR_BITS));

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      csb_q        <= 1'b1;
      sck_q        <= 1'b0;
      hdr_cnt_q    <= '0;
      data_cnt_q   <= '0;
      beat_valid_q <= 1'b0;
    end else begin
      csb_q <= !start_i;
      // toggles while selected, forced low otherwise
      sck_q <= sck_rise;
      if (csb_q) begin
        hdr_cnt_q  <= '0;
        data_cnt_q <= '0;
      end else if (sck_rise) begin
        if (!hdr_done) begin
          hdr_cnt_q <= hdr_cnt_q + 1'b1;
        end else begin
          data_cnt_q <= data_cnt_q + 1'b1;
        end
      end
      beat_valid_q <= sck_rise && hdr_done &&
                      (data_cnt_q == DATA_CNT_BITS'(sys_pkg::WORD_BITS - 1));
    end
  end

  // header shifts on falling sck so mosi is stable at each rise
  always_ff @(posedge clk_gen) begin
    if (csb_q) begin
      hdr_q <= {board_pkg::FLASH_READ_CMD, FLASH_BASE};
    end else if (sck_fall) begin
      hdr_q <= {hdr_q[HDR_BITS-2:0], 1'b0};
    end
    if (sck_rise && hdr_done) begin
      data_q <= {data_q[sys_pkg::WORD_BITS-2:0], miso_i};
    end
  end

  assign spi_o.csb  = csb_q;
  assign spi_o.sck  = sck_q;
  assign spi_o.mosi = !csb_q && hdr_q[HDR_BITS-1];

  // data_q already holds the complete word in the strobe cycle
  assign beat_o.valid = beat_valid_q;
  assign beat_o.word  = data_q;

endmodule

`default_nettype wire

/* boot/boot_fsm.sv */
// picks the boot source once after reset and counts WORDS image beats
// the source is fixed until the next reset; beats after done are dropped
`timescale 1ns/1ps
`default_nettype none

module boot_fsm #(
  parameter int unsigned WORDS = 4
) (
  input  logic           clk_gen,
  input  logic           rst_n,
  input  logic           boot_select_i,
  input  sys_pkg::beat_t host_beat_i,
  input  sys_pkg::beat_t flash_beat_i,
  output logic           flash_start_o,
  output sys_pkg::beat_t beat_o,
  output logic           done_o
);

  localparam int CNT_BITS = $clog2(WORDS + 1);

  sys_pkg::boot_state_t state_q;
  sys_pkg::boot_state_t state_d;
  logic [CNT_BITS-1:0]  count_q;
  logic                 last_beat;

  // only the selected source reaches the checksum
  always_comb begin
    case (state_q)
      sys_pkg::FLASH_LOAD: beat_o = flash_beat_i;
      sys_pkg::HOST_LOAD:  beat_o = host_beat_i;
      default:             beat_o = '0;
    endcase
  end

  assign last_beat = beat_o.valid && (count_q == CNT_BITS'(WORDS - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      sys_pkg::IDLE: begin
        if (boot_select_i) begin
          state_d = sys_pkg::FLASH_LOAD;
        end else begin
          state_d = sys_pkg::HOST_LOAD;
        end
      end
      sys_pkg::FLASH_LOAD, sys_pkg::HOST_LOAD: begin
        if (last_beat) begin
          state_d = sys_pkg::DONE;
        end
      end
      default: state_d = state_q;
    endcase
  end

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= sys_pkg::IDLE;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      if (beat_o.valid) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // leaving FLASH_LOAD drops start and stops the reader
  assign flash_start_o = (state_q == sys_pkg::FLASH_LOAD);

  // also high with the last beat, so exit valid lines up with the final sum
  assign done_o = (state_q == sys_pkg::DONE) || last_beat;

endmodule

`default_nettype wire

/* logic/heartbeat_counter.sv */
// blink counter, led period is 2^HEARTBEAT_BITS cycles of clk_gen
// use a small width in simulation so the led toggles early
`timescale 1ns/1ps
`default_nettype none

module heartbeat_counter #(
  parameter int HEARTBEAT_BITS = 27
) (
  input  logic clk_gen,
  input  logic rst_n,
  output logic led_o
);

  logic [HEARTBEAT_BITS-1:0] count_q;

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  // top bit gives a 50% duty blink
  assign led_o = count_q[HEARTBEAT_BITS-1];

endmodule

`default_nettype wire

/* logic/reset_sync.sv */
// button reset to synchronized active-low reset
// asserts at once, releases on the second clk_gen edge after rst_i falls
`timescale 1ns/1ps
`default_nettype none

module reset_sync (
  input  logic clk_gen,
  input  logic rst_i,
  output logic rst_n_o
);

  logic [1:0] sync_q;

  // two-flop chain, cleared directly by the button
  always_ff @(posedge clk_gen or posedge rst_i) begin
    if (rst_i) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_n_o = sync_q[1];

endmodule

`default_nettype wire

/* common/sys_pkg.sv */
// boot image types shared by the boot, flash and checksum blocks
// a beat is a one-cycle strobe; exit is a level that holds until reset
`default_nettype none

package sys_pkg;

  localparam int WORD_BITS = 32;

  typedef logic [WORD_BITS-1:0] word_t;

  // one image word, valid for a single cycle
  typedef struct packed {
    logic  valid;
    word_t word;
  } beat_t;

  // final result seen by the host
  typedef struct packed {
    logic  valid;
    word_t value;
  } exit_t;

  typedef enum logic [1:0] {
    IDLE,
    FLASH_LOAD,
    HOST_LOAD,
    DONE
  } boot_state_t;

endpackage

`default_nettype wire

/* common/board_pkg.sv */
// board pin constants for the serial boot flash
// assumes a single-lane SPI flash that accepts the plain 0x03 read with a 24-bit address
`default_nettype none

package board_pkg;

  localparam int FLASH_CMD_BITS = 8;
  localparam int FLASH_ADDR_BITS = 24;

  typedef logic [FLASH_CMD_BITS-1:0] flash_cmd_t;
  typedef logic [FLASH_ADDR_BITS-1:0] flash_addr_t;

  // slow read, no dummy cycles
  localparam flash_cmd_t FLASH_READ_CMD = 8'h03;

  // master-driven flash pins, csb is active low
  typedef struct packed {
    logic csb;
    logic sck;
    logic mosi;
  } spi_pins_t;

endpackage

`default_nettype wire
